// ==== Bender.yml ====
package:
  name: ppu

sources:
  - logic/ppu_pkg.sv
  - logic/ppu_regs_if.sv
  - logic/ppu_tile_if.sv
  - logic/ppu_regs.sv
  - logic/ppu_line_timing.sv
  - logic/ppu_bg_fetcher.sv
  - logic/ppu_pixel_shifter.sv
  - logic/ppu_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/ppu_tb.sv

// ==== all.f ====
+incdir+dv
logic/ppu_pkg.sv
logic/ppu_regs_if.sv
logic/ppu_tile_if.sv
logic/ppu_regs.sv
logic/ppu_line_timing.sv
logic/ppu_bg_fetcher.sv
logic/ppu_pixel_shifter.sv
logic/ppu_top.sv
dv/ppu_tb.sv

// ==== dv/ppu_tests.svh ====
// ppu directed tests with a background reference pixel model

    localparam logic [1:0] M_HBLANK = 2'd0;
    localparam logic [1:0] M_VBLANK = 2'd1;
    localparam logic [1:0] M_SCAN   = 2'd2;
    localparam logic [1:0] M_DRAW   = 2'd3;

    localparam int VRAM_BASE = 'h8000;
    localparam int MAP_LO    = 'h9800;
    localparam int MAP_HI    = 'h9C00;
    localparam int TILE_SIGN = 'h9000;  // signed tile 0

    // colour index of screen pixel (x, line) as the vram contents define it
    function automatic logic [1:0] ref_pixel(input int line, input int x,
                                             input logic unsigned_tiles, input logic map_hi,
                                             input logic bg_on, input logic [7:0] scx,
                                             input logic [7:0] scy);
        logic [7:0] bg_x;
        logic [7:0] bg_y;
        logic [7:0] tile_no;
        int         map_addr;
        int         row_addr;
        int         bit_no;
        bg_x     = 8'(x) + scx;     // wraps at 256
        bg_y     = 8'(line) + scy;
        map_addr = (map_hi ? MAP_HI : MAP_LO) + 32 * int'(bg_y[7:3]) + int'(bg_x[7:3]);
        tile_no  = vram[map_addr - VRAM_BASE];
        if (unsigned_tiles) begin
            row_addr = VRAM_BASE + 16 * int'(tile_no);
        end else begin
            row_addr = TILE_SIGN + 16 * int'($signed(tile_no));
        end
        row_addr = row_addr + 2 * int'(bg_y[2:0]) - VRAM_BASE;
        bit_no   = 7 - int'(bg_x[2:0]);
        if (!bg_on) begin
            return 2'b00;
        end
        return {vram[row_addr + 1][bit_no], vram[row_addr][bit_no]};
    endfunction

    // clocks spent in mode m from now, leaves the tb at the first clock of the next mode
    task automatic count_mode(input logic [1:0] m, output int n);
        n = 0;
        while (lcd_mode == m && n < 1000) begin
            n++;
            @(negedge clk);
        end
    endtask

    task automatic capture_lines(input string name, input int nlines, input logic uns,
                                 input logic map_hi, input logic bg_on,
                                 input logic [7:0] scx, input logic [7:0] scy);
        int         tries;
        int         cnt;
        logic [1:0] exp;
        for (int line = 0; line < nlines; line++) begin
            tries = 0;
            while (lcd_mode != M_DRAW && tries < 1000) begin
                @(negedge clk);
                tries++;
            end
            if (tries >= 1000) begin
                $display("%s: draw never started on line %0d", name, line);
                errors++;
            end
            cnt = 0;
            while (lcd_mode == M_DRAW && cnt < 1000) begin
                if (px_valid) begin
                    exp = ref_pixel(line, cnt, uns, map_hi, bg_on, scx, scy);
                    if (px !== exp) begin
                        $display("Error %s line %0d x %0d: expected %0d, got %0d",
                                 name, line, cnt, exp, px);
                        errors++;
                    end
                    cnt++;
                end
                @(negedge clk);
            end
            if (cnt != 160) begin
                $display("Error %s line %0d pixel count: expected 160, got %0d", name, line, cnt);
                errors++;
            end
        end
    endtask

    task automatic write_readback(input logic [15:0] a, input logic [7:0] v);
        logic [7:0] d;
        bus_write(a, v);
        bus_read(a, d);
        if (d !== v) begin
            $display("Error registers %h: expected %h, got %h", a, v, d);
            errors++;
        end
    endtask

    task automatic test_registers();
        logic [7:0] d;
        if ({vram_rd, px_valid, irq_vblank, irq_stat} !== 4'b0000) begin
            $display("registers: outputs not idle after reset");
            errors++;
        end
        write_readback(16'hFF40, 8'h55);  // bit 7 clear keeps the display off
        write_readback(16'hFF42, 8'hA5);
        write_readback(16'hFF43, 8'h3C);
        write_readback(16'hFF45, 8'h96);
        bus_write(16'hFF41, 8'hFF);
        bus_read(16'hFF41, d);
        if (d !== 8'hF8) begin                 // ly 0 vs lyc 96, mode hblank
            $display("Error registers stat: expected f8, got %h", d);
            errors++;
        end
        bus_write(16'hFF44, 8'h33);
        bus_read(16'hFF44, d);
        if (d !== 8'h00) begin
            $display("Error registers ly: expected 00, got %h", d);
            errors++;
        end
        bus_read(16'hFF46, d);
        if (d !== 8'hFF) begin
            $display("Error registers unmapped: expected ff, got %h", d);
            errors++;
        end
        bus_write(16'hFF40, 8'h00);
        bus_write(16'hFF41, 8'h00);
        bus_read(16'hFF41, d);
        if (d !== 8'h80) begin                 // bit 7 reads 1 without being written
            $display("Error registers stat cleared: expected 80, got %h", d);
            errors++;
        end
        bus_write(16'hFF45, 8'h00);
    endtask

    task automatic test_frame_timing();
        logic [7:0] d;
        int         n;
        int         bad;
        int         draw;
        draw = 164 + 3;                        // scx mod 8 is 3
        bus_write(16'hFF43, 8'h03);
        bus_write(16'hFF40, 8'h91);
        for (int line = 0; line < 2; line++) begin
            count_mode(M_SCAN, n);
            if (n != 80) begin
                $display("Error frame timing scan: expected 80, got %0d", n);
                errors++;
            end
            count_mode(M_DRAW, n);
            if (n != draw) begin
                $display("Error frame timing draw: expected %0d, got %0d", draw, n);
                errors++;
            end
            count_mode(M_HBLANK, n);
            if (n != 456 - 80 - draw) begin
                $display("Error frame timing hblank: expected %0d, got %0d", 456 - 80 - draw, n);
                errors++;
            end
        end
        n = 0;
        while (!irq_vblank && n < FRAME_CLOCKS) begin
            @(negedge clk);
            n++;
        end
        if (!irq_vblank) begin
            $display("frame timing: vblank interrupt never came");
            errors++;
        end else begin
            bus_read(16'hFF44, d);
            if (d !== 8'd144) begin
                $display("Error frame timing ly at vblank: expected 144, got %0d", d);
                errors++;
            end
            bad = (lcd_mode !== M_VBLANK);
            n   = 0;
            do begin
                @(negedge clk);
                n++;
                if (n < 10 * 456 && lcd_mode !== M_VBLANK) begin
                    bad++;
                end
            end while (!irq_vblank && n <= FRAME_CLOCKS);
            if (bad != 0) begin
                $display("frame timing: mode left vblank on %0d clocks of lines 144-153", bad);
                errors++;
            end
            if (n != FRAME_CLOCKS) begin
                $display("Error frame timing vblank period: expected %0d, got %0d",
                         FRAME_CLOCKS, n);
                errors++;
            end
        end
        bus_write(16'hFF40, 8'h00);
        bus_write(16'hFF43, 8'h00);
    endtask

    task automatic test_bg_unsigned();
        bus_write(16'hFF42, 8'hFA);            // bg_y wraps through 255
        bus_write(16'hFF43, 8'hF3);            // column wraps through 31
        bus_write(16'hFF40, 8'h99);
        capture_lines("bg unsigned", 10, 1'b1, 1'b1, 1'b1, 8'hF3, 8'hFA);
        bus_write(16'hFF40, 8'h00);
    endtask

    task automatic test_bg_signed();
        bus_write(16'hFF42, 8'h11);
        bus_write(16'hFF43, 8'h05);
        bus_write(16'hFF40, 8'h81);
        capture_lines("bg signed", 4, 1'b0, 1'b0, 1'b1, 8'h05, 8'h11);
        bus_write(16'hFF40, 8'h00);
        bus_write(16'hFF40, 8'h90);
        capture_lines("bg disabled", 1, 1'b1, 1'b0, 1'b0, 8'h05, 8'h11);
        bus_write(16'hFF40, 8'h00);
    endtask

    task automatic test_stat_irq();
        logic [7:0] d;
        int         pulses;
        bus_write(16'hFF45, 8'h0A);
        bus_write(16'hFF41, 8'h40);            // lyc source only
        bus_write(16'hFF40, 8'h91);
        pulses = 0;
        for (int i = 0; i < 16 * 456; i++) begin
            if (irq_stat) begin
                pulses++;
                bus_read(16'hFF44, d);
                if (d !== 8'd10) begin
                    $display("Error stat lyc ly: expected 10, got %0d", d);
                    errors++;
                end
                bus_read(16'hFF41, d);
                if (d[2] !== 1'b1) begin
                    $display("Error stat coincidence: expected 1, got %b", d[2]);
                    errors++;
                end
            end
            @(negedge clk);
        end
        if (pulses != 1) begin
            $display("Error stat lyc pulses: expected 1, got %0d", pulses);
            errors++;
        end
        bus_write(16'hFF40, 8'h00);
        bus_write(16'hFF41, 8'h08);            // hblank source
        bus_write(16'hFF40, 8'h91);
        pulses = 0;
        for (int i = 0; i < 10 * 456; i++) begin
            pulses += irq_stat;
            @(negedge clk);
        end
        if (pulses != 10) begin
            $display("Error stat hblank pulses: expected 10, got %0d", pulses);
            errors++;
        end
        bus_write(16'hFF40, 8'h00);
        bus_write(16'hFF41, 8'h00);
        bus_write(16'hFF45, 8'h00);            // ly equals lyc while off
        bus_write(16'hFF40, 8'h11);
        bus_write(16'hFF41, 8'h78);            // every source turns on with the display off
        pulses = 0;
        for (int i = 0; i < 2 * 456; i++) begin
            pulses += irq_stat;
            @(negedge clk);
        end
        if (pulses != 0) begin
            $display("Error stat display off pulses: expected 0, got %0d", pulses);
            errors++;
        end
        bus_write(16'hFF41, 8'h00);
        bus_write(16'hFF40, 8'h00);
    endtask

// ==== dv/ppu_tb.sv ====
// ppu testbench: clock, reset, vram model, cpu bus tasks, watchdog and summary
`timescale 1ns/1ps

module ppu_tb;

    localparam int CLK_NS       = 40;
    localparam int FRAME_CLOCKS = 154 * 456;

    logic        clk;
    logic        rst;
    logic [15:0] addr;
    logic        wr;
    logic        rd;
    logic [7:0]  wr_data;
    logic [7:0]  rd_data;
    logic        irq_vblank;
    logic        irq_stat;
    logic [1:0]  lcd_mode;
    logic        vram_rd;
    logic [15:0] vram_addr;
    logic [7:0]  vram_data;
    logic [1:0]  px;
    logic        px_valid;

    logic [7:0]  vram [0:8191];  // 8000-9fff
    logic [12:0] vram_idx;       // address taken with vram_rd
    logic        vram_pend;
    int          errors;

    ppu_top i_dut (
        .clk        (clk),
        .rst        (rst),
        .addr       (addr),
        .wr         (wr),
        .rd         (rd),
        .wr_data    (wr_data),
        .rd_data    (rd_data),
        .irq_vblank (irq_vblank),
        .irq_stat   (irq_stat),
        .lcd_mode   (lcd_mode),
        .vram_rd    (vram_rd),
        .vram_addr  (vram_addr),
        .vram_data  (vram_data),
        .px         (px),
        .px_valid   (px_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // read data shows up in the clock after the request
    always @(posedge clk) begin
        vram_pend <= vram_rd;
        vram_idx  <= vram_addr[12:0];
    end

    always @(negedge clk) begin
        if (vram_pend) begin
            vram_data <= vram[vram_idx];
        end
    end

    // 16-bit fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic fill_vram();
        logic [15:0] s;
        logic [7:0]  b;
        s = 16'd22;
        for (int a = 0; a < 8192; a++) begin
            for (int i = 0; i < 8; i++) begin
                s = lfsr_next(s);
                b = {b[6:0], s[0]};  // one step per bit
            end
            vram[a] = b;
        end
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        @(negedge clk);
        addr    = a;
        wr_data = d;
        wr      = 1'b1;
        @(negedge clk);
        wr = 1'b0;
    endtask

    // called in the low phase, the read mux is combinational
    task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
        addr = a;
        rd   = 1'b1;
        #1;
        d  = rd_data;
        rd = 1'b0;
    endtask

    `include "ppu_tests.svh"

    initial begin
        rst       = 1'b1;
        addr      = 16'h0000;
        wr        = 1'b0;
        rd        = 1'b0;
        wr_data   = 8'h00;
        vram_data = 8'h00;
        vram_pend = 1'b0;
        errors    = 0;
        fill_vram();
        repeat (2) @(negedge clk);
        rst = 1'b0;
        test_registers();
        test_frame_timing();
        test_bg_unsigned();
        test_bg_signed();
        test_stat_irq();
        $display("tests done, %0d errors", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // six frames cover every test with room to spare
    initial begin
        #(6 * FRAME_CLOCKS * CLK_NS);
        $display("timeout: tests still running after six frames, %0d errors", errors);
        $display("Something failed");
        $finish;
    end

endmodule

// ==== logic/ppu_bg_fetcher.sv ====
// background fetcher: map and tile row address generation and vram read sequence
`timescale 1ns/1ps

module ppu_bg_fetcher (
    input  logic         clk,
    input  logic         rst,
    input  logic [7:0]   vram_data,
    output logic         vram_rd,
    output logic [15:0]  vram_addr,
    ppu_regs_if.view     regs_if,
    ppu_tile_if.fetcher  tile_if
);

    typedef enum logic [1:0] {
        FS_MAP,   // idle, map read issued with the request
        FS_LO,    // tile number on vram_data, read low byte
        FS_HI,    // low byte on vram_data, read high byte
        FS_DATA   // high byte on vram_data
    } fetch_state_e;

    fetch_state_e state;
    logic [4:0]   col;        // next tile column, wraps at 32
    logic [4:0]   req_col;
    logic [7:0]   bg_y;       // background line, ly + scy mod 256
    logic [15:0]  map_base;
    logic [15:0]  map_addr;
    logic [15:0]  tile_base;
    logic [15:0]  tile_addr;
    logic [15:0]  row_addr;   // low byte address of the current row

    assign bg_y     = regs_if.ly + regs_if.scy;
    assign req_col  = regs_if.line_start ? regs_if.scx[7:3] : col;
    assign map_base = regs_if.lcdc.flags.bg_map ? ppu_pkg::MAP_BASE_HI : ppu_pkg::MAP_BASE_LO;
    assign map_addr = map_base + 16'(ppu_pkg::MAP_ROW_TILES) * 16'(bg_y[7:3]) + 16'(req_col);

    always_comb begin
        if (regs_if.lcdc.flags.tile_sel) begin
            tile_base = ppu_pkg::TILE_BASE_UNSIGNED + {4'b0, vram_data, 4'b0};
        end else begin
            tile_base = ppu_pkg::TILE_BASE_SIGNED + {{4{vram_data[7]}}, vram_data, 4'b0};
        end
        tile_addr = tile_base + {12'b0, bg_y[2:0], 1'b0};  // two bytes per tile row
    end

    always_comb begin
        vram_rd   = 1'b0;
        vram_addr = map_addr;
        case (state)
            FS_MAP: vram_rd = tile_if.fetch_req;
            FS_LO: begin
                vram_rd   = 1'b1;
                vram_addr = tile_addr;
            end
            FS_HI: begin
                vram_rd   = 1'b1;
                vram_addr = row_addr + 16'd1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= FS_MAP;
            col               <= 5'd0;
            tile_if.row_valid <= 1'b0;
        end else begin
            tile_if.row_valid <= (state == FS_DATA);
            if (tile_if.fetch_req) begin
                col <= req_col + 5'd1;
            end
            case (state)
                FS_MAP:  state <= tile_if.fetch_req ? FS_LO : FS_MAP;
                FS_LO:   state <= FS_HI;
                FS_HI:   state <= FS_DATA;
                default: state <= FS_MAP;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FS_LO) begin
            row_addr <= tile_addr;
        end
        if (state == FS_HI) begin
            tile_if.row_lo <= regs_if.lcdc.flags.bg_en ? vram_data : 8'h00;
        end
        if (state == FS_DATA) begin
            tile_if.row_hi <= regs_if.lcdc.flags.bg_en ? vram_data : 8'h00;
        end
    end

endmodule

// ==== logic/ppu_line_timing.sv ====
// dot and line counters, lcd mode sequencing and vertical blank interrupt
`timescale 1ns/1ps

module ppu_line_timing (
    input  logic       clk,
    input  logic       rst,
    input  logic       line_done,
    output logic       irq_vblank,
    ppu_regs_if.timing regs_if
);

    logic [8:0]         dot;      // 0..455 within the line
    logic [7:0]         ly;
    logic               drawing;  // set from dot 80 until the shifter finishes
    logic               enable;
    logic               visible;
    logic               line_end;
    ppu_pkg::lcd_mode_e mode;

    assign enable   = regs_if.lcdc.flags.lcd_en;
    assign visible  = (ly < 8'(ppu_pkg::VISIBLE_LINES));
    assign line_end = (dot == 9'(ppu_pkg::DOTS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (rst || !enable) begin
            dot        <= 9'd0;
            ly         <= 8'd0;
            drawing    <= 1'b0;
            irq_vblank <= 1'b0;
        end else begin
            irq_vblank <= line_end && (ly == 8'(ppu_pkg::VISIBLE_LINES - 1));
            if (line_end) begin
                dot <= 9'd0;
                if (ly == 8'(ppu_pkg::LINES_PER_FRAME - 1)) begin
                    ly <= 8'd0;
                end else begin
                    ly <= ly + 8'd1;
                end
            end else begin
                dot <= dot + 9'd1;
            end
            if (visible && dot == 9'(ppu_pkg::SCAN_DOTS - 1)) begin
                drawing <= 1'b1;
            end else if (line_done || line_end) begin
                drawing <= 1'b0;                         // draw ends the clock after line_done
            end
        end
    end

    always_comb begin
        if (!enable) begin
            mode = ppu_pkg::MODE_HBLANK;
        end else if (!visible) begin
            mode = ppu_pkg::MODE_VBLANK;
        end else if (dot < 9'(ppu_pkg::SCAN_DOTS)) begin
            mode = ppu_pkg::MODE_SCAN;                   // scan only as timing, no oam search
        end else if (drawing) begin
            mode = ppu_pkg::MODE_DRAW;
        end else begin
            mode = ppu_pkg::MODE_HBLANK;
        end
    end

    assign regs_if.mode       = mode;
    assign regs_if.ly         = ly;
    assign regs_if.line_start = enable && drawing && (dot == 9'(ppu_pkg::SCAN_DOTS));

endmodule

// ==== logic/ppu_pixel_shifter.sv ====
// two-plane background shifter with fine scroll discard and end of line detection
`timescale 1ns/1ps

module ppu_pixel_shifter (
    input  logic         clk,
    input  logic         rst,
    output logic [1:0]   px,
    output logic         px_valid,
    output logic         line_done,
    ppu_regs_if.view     regs_if,
    ppu_tile_if.shifter  tile_if
);

    logic [7:0] sh_lo;
    logic [7:0] sh_hi;
    logic [7:0] cur_lo;    // plane bytes feeding this clock's pixel
    logic [7:0] cur_hi;
    logic [3:0] remain;    // bits left in the shift register
    logic [2:0] discard;   // fine scroll pixels still to drop
    logic [7:0] x;
    logic       active;
    logic       run;
    logic       have_px;

    // a new row is used on the clock it arrives
    assign cur_lo  = tile_if.row_valid ? tile_if.row_lo : sh_lo;
    assign cur_hi  = tile_if.row_valid ? tile_if.row_hi : sh_hi;
    assign run     = active && regs_if.lcdc.flags.lcd_en;
    assign have_px = run && (tile_if.row_valid || remain != 4'd0);

    assign px        = {cur_hi[7], cur_lo[7]};
    assign px_valid  = have_px && (discard == 3'd0);
    assign line_done = px_valid && (x == 8'(ppu_pkg::SCREEN_WIDTH - 1));

    assign tile_if.fetch_req = regs_if.line_start ||
                               (run && remain == 4'(ppu_pkg::FETCH_CYCLES));

    always_ff @(posedge clk) begin
        if (rst) begin
            active  <= 1'b0;
            remain  <= 4'd0;
            discard <= 3'd0;
            x       <= 8'd0;
        end else if (regs_if.line_start) begin
            active  <= 1'b1;
            remain  <= 4'd0;
            discard <= regs_if.scx[2:0];
            x       <= 8'd0;
        end else begin
            if (line_done || !regs_if.lcdc.flags.lcd_en) begin
                active <= 1'b0;                      // late row of the last request is ignored
            end
            if (have_px) begin
                remain <= tile_if.row_valid ? 4'd7 : remain - 4'd1;
                if (discard != 3'd0) begin
                    discard <= discard - 3'd1;
                end
                if (px_valid) begin
                    x <= x + 8'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (have_px) begin
            sh_lo <= {cur_lo[6:0], 1'b0};  // msb first
            sh_hi <= {cur_hi[6:0], 1'b0};
        end
    end

endmodule

// ==== logic/ppu_pkg.sv ====
// ppu shared definitions: lcd geometry, register map, mode encoding and lcdc layout
package ppu_pkg;

    // cpu-visible register addresses
    localparam logic [15:0] ADDR_LCDC = 16'hFF40;
    localparam logic [15:0] ADDR_STAT = 16'hFF41;
    localparam logic [15:0] ADDR_SCY  = 16'hFF42;
    localparam logic [15:0] ADDR_SCX  = 16'hFF43;
    localparam logic [15:0] ADDR_LY   = 16'hFF44;  // read only
    localparam logic [15:0] ADDR_LYC  = 16'hFF45;

    // frame geometry, one dot per clock
    localparam int DOTS_PER_LINE   = 456;
    localparam int SCAN_DOTS       = 80;   // mode 2 length
    localparam int VISIBLE_LINES   = 144;
    localparam int LINES_PER_FRAME = 154;
    localparam int SCREEN_WIDTH    = 160;

    // vram layout
    localparam logic [15:0] MAP_BASE_LO        = 16'h9800;
    localparam logic [15:0] MAP_BASE_HI        = 16'h9C00;
    localparam logic [15:0] TILE_BASE_UNSIGNED = 16'h8000;
    localparam logic [15:0] TILE_BASE_SIGNED   = 16'h9000;  // tile 0 sits here, -128 at 8800
    localparam int          MAP_ROW_TILES      = 32;

    localparam int FETCH_CYCLES = 4;  // fetch request to row delivery

    // values as reported in stat[1:0]
    typedef enum logic [1:0] {
        MODE_HBLANK = 2'd0,
        MODE_VBLANK = 2'd1,
        MODE_SCAN   = 2'd2,
        MODE_DRAW   = 2'd3
    } lcd_mode_e;

    typedef struct packed {
        logic lcd_en;    // bit 7
        logic win_map;   // window not implemented
        logic win_en;
        logic tile_sel;  // 1: 8000 unsigned, 0: 9000 signed
        logic bg_map;    // 1: 9c00, 0: 9800
        logic obj_size;  // sprites not implemented
        logic obj_en;
        logic bg_en;     // bit 0
    } lcdc_flags_t;

    // the bus sees a byte, the display logic sees flags
    typedef union packed {
        logic [7:0]  raw;
        lcdc_flags_t flags;
    } lcdc_t;

endpackage

// ==== logic/ppu_regs.sv ====
// lcd register bank with cpu read mux, stat status bits and stat interrupt edge detect
`timescale 1ns/1ps

module ppu_regs (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] addr,
    input  logic        wr,
    input  logic        rd,
    input  logic [7:0]  wr_data,
    output logic [7:0]  rd_data,
    output logic        irq_stat,
    ppu_regs_if.regs    regs_if
);

    logic [3:0] stat_sel;     // stat bits 6:3, interrupt sources
    logic       lyc_match;
    logic [7:0] stat_rd;
    logic       stat_cond;
    logic       stat_cond_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            regs_if.lcdc.raw <= 8'h00;
            stat_sel         <= 4'h0;
            regs_if.scy      <= 8'h00;
            regs_if.scx      <= 8'h00;
            regs_if.lyc      <= 8'h00;
        end else if (wr) begin
            case (addr)
                ppu_pkg::ADDR_LCDC: regs_if.lcdc.raw <= wr_data;
                ppu_pkg::ADDR_STAT: stat_sel <= wr_data[6:3];  // low bits are status
                ppu_pkg::ADDR_SCY:  regs_if.scy <= wr_data;
                ppu_pkg::ADDR_SCX:  regs_if.scx <= wr_data;
                ppu_pkg::ADDR_LYC:  regs_if.lyc <= wr_data;
                default: ;                                     // ly and unmapped ignore writes
            endcase
        end
    end

    assign lyc_match = (regs_if.ly == regs_if.lyc);
    assign stat_rd   = {1'b1, stat_sel, lyc_match, regs_if.mode};

    always_comb begin
        rd_data = 8'hFF;
        if (rd) begin
            case (addr)
                ppu_pkg::ADDR_LCDC: rd_data = regs_if.lcdc.raw;
                ppu_pkg::ADDR_STAT: rd_data = stat_rd;
                ppu_pkg::ADDR_SCY:  rd_data = regs_if.scy;
                ppu_pkg::ADDR_SCX:  rd_data = regs_if.scx;
                ppu_pkg::ADDR_LY:   rd_data = regs_if.ly;
                ppu_pkg::ADDR_LYC:  rd_data = regs_if.lyc;
                default:            rd_data = 8'hFF;
            endcase
        end
    end

    // shared stat line, any enabled source holds it high
    always_comb begin
        stat_cond = (stat_sel[3] && lyc_match) ||
                    (stat_sel[0] && regs_if.mode == ppu_pkg::MODE_HBLANK) ||
                    (stat_sel[2] && regs_if.mode == ppu_pkg::MODE_SCAN) ||
                    ((stat_sel[1] || stat_sel[2]) && regs_if.mode == ppu_pkg::MODE_VBLANK);
        stat_cond = stat_cond && regs_if.lcdc.flags.lcd_en;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stat_cond_q <= 1'b0;
        end else begin
            stat_cond_q <= stat_cond;
        end
    end

    assign irq_stat = stat_cond && !stat_cond_q;  // rising edge only

endmodule

// ==== logic/ppu_regs_if.sv ====
// register settings and line status shared by the ppu register bank, timing and fetch path
`timescale 1ns/1ps

interface ppu_regs_if;

    ppu_pkg::lcdc_t     lcdc;
    logic [7:0]         scx;
    logic [7:0]         scy;
    logic [7:0]         lyc;
    logic [7:0]         ly;
    ppu_pkg::lcd_mode_e mode;
    logic               line_start;  // one clock, first dot of draw

    modport regs (output lcdc, scx, scy, lyc, input ly, mode);

    modport timing (input lcdc, output ly, mode, line_start);

    modport view (input lcdc, scx, scy, lyc, ly, mode, line_start);

endinterface

// ==== logic/ppu_tile_if.sv ====
// tile row request and delivery between the pixel shifter and the background fetcher
`timescale 1ns/1ps

interface ppu_tile_if;

    logic       fetch_req;  // single-cycle strobe, no back-pressure
    logic [7:0] row_lo;
    logic [7:0] row_hi;
    logic       row_valid;  // fetch_cycles after fetch_req

    modport fetcher (input fetch_req, output row_lo, row_hi, row_valid);

    modport shifter (output fetch_req, input row_lo, row_hi, row_valid);

endinterface

// ==== logic/ppu_top.sv ====
// ppu top level: register bank, line timing, background fetcher and pixel shifter
`timescale 1ns/1ps

module ppu_top (
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] addr,
    input  logic        wr,
    input  logic        rd,
    input  logic [7:0]  wr_data,
    output logic [7:0]  rd_data,
    output logic        irq_vblank,
    output logic        irq_stat,
    output logic [1:0]  lcd_mode,
    output logic        vram_rd,
    output logic [15:0] vram_addr,
    input  logic [7:0]  vram_data,
    output logic [1:0]  px,
    output logic        px_valid
);

    logic line_done;  // last pixel of the line

    ppu_regs_if regs_if ();
    ppu_tile_if tile_if ();

    ppu_regs i_regs (
        .clk      (clk),
        .rst      (rst),
        .addr     (addr),
        .wr       (wr),
        .rd       (rd),
        .wr_data  (wr_data),
        .rd_data  (rd_data),
        .irq_stat (irq_stat),
        .regs_if  (regs_if.regs)
    );

    ppu_line_timing i_timing (
        .clk        (clk),
        .rst        (rst),
        .line_done  (line_done),
        .irq_vblank (irq_vblank),
        .regs_if    (regs_if.timing)
    );

    ppu_bg_fetcher i_fetcher (
        .clk       (clk),
        .rst       (rst),
        .vram_data (vram_data),
        .vram_rd   (vram_rd),
        .vram_addr (vram_addr),
        .regs_if   (regs_if.view),
        .tile_if   (tile_if.fetcher)
    );

    ppu_pixel_shifter i_shifter (
        .clk       (clk),
        .rst       (rst),
        .px        (px),
        .px_valid  (px_valid),
        .line_done (line_done),
        .regs_if   (regs_if.view),
        .tile_if   (tile_if.shifter)
    );

    assign lcd_mode = regs_if.mode;

endmodule
